// ==== rtl/warp_decode.sv ====
`timescale 1ns/1ps

`include "warp_settings.svh"

module warp_decode (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_input_valid,
    output logic                    o_input_ready,
    input  logic [`WARP_INST_W-1:0] i_inst0,
    input  logic [`WARP_INST_W-1:0] i_inst1,
    output logic                    o_output_valid,
    input  logic                    i_output_ready,
    output warp_pkg::bundle_t       o_bundle0,
    output warp_pkg::bundle_t       o_bundle1
);
    import warp_pkg::*;

    // lane 0 is the older instruction of the pair
    bundle_t [`WARP_LANES-1:0] dec_bundles;
    bundle_t [`WARP_LANES-1:0] out_bundles;

    warp_udecode u_udecode0 (
        .i_inst  (i_inst0),
        .o_bundle(dec_bundles[0])
    );

    warp_udecode u_udecode1 (
        .i_inst  (i_inst1),
        .o_bundle(dec_bundles[1])
    );

    // absorbs issue stalls, both lanes move together
    warp_skid #(
        .DEPTH_LANES(`WARP_LANES)
    ) u_skid (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_input_valid (i_input_valid),
        .o_input_ready (o_input_ready),
        .i_input_data  (dec_bundles),
        .o_output_valid(o_output_valid),
        .i_output_ready(i_output_ready),
        .o_output_data (out_bundles)
    );

    assign o_bundle0 = out_bundles[0];
    assign o_bundle1 = out_bundles[1];

endmodule

// ==== rtl/warp_imm_gen.sv ====
`timescale 1ns/1ps

`include "warp_settings.svh"

module warp_imm_gen (
    input  logic [`WARP_INST_W-1:0] i_inst,
    input  warp_pkg::major_opcode_e i_opcode,
    output logic [`WARP_IMM_W-1:0]  o_imm
);
    import warp_pkg::*;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } imm_fmt_e;

    imm_fmt_e fmt;
    logic     sign;

    // every format takes its sign from bit 31
    assign sign = i_inst[31];

    // opcode to format
    always_comb begin
        case (i_opcode)
            opc_op_imm, opc_op_imm_32, opc_jalr, opc_load: fmt = fmt_i;
            opc_store:                                      fmt = fmt_s;
            opc_branch:                                     fmt = fmt_b;
            opc_lui, opc_auipc:                             fmt = fmt_u;
            opc_jal:                                        fmt = fmt_j;
            default:                                        fmt = fmt_r;
        endcase
    end

    always_comb begin
        case (fmt)
            fmt_i: o_imm = {{20{sign}}, i_inst[31:20]};
            fmt_s: o_imm = {{20{sign}}, i_inst[31:25], i_inst[11:7]};
            // branch offsets are halfword aligned
            fmt_b: o_imm = {{20{sign}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
            // upper immediate, low 12 bits clear
            fmt_u: o_imm = {i_inst[31:12], 12'b0};
            fmt_j: o_imm = {{12{sign}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
            // r format keeps funct7 bits in 11:5, low bits clear
            default: o_imm = {{21{sign}}, i_inst[30:25], 5'b0};
        endcase
    end

endmodule

// ==== rtl/warp_pkg.sv ====
`include "warp_settings.svh"

package warp_pkg;

    // major opcode, taken from inst[6:2]
    typedef enum logic [4:0] {
        opc_load      = 5'b00000,
        opc_load_fp   = 5'b00001,
        opc_custom0   = 5'b00010,
        opc_misc_mem  = 5'b00011,
        opc_op_imm    = 5'b00100,
        opc_auipc     = 5'b00101,
        opc_op_imm_32 = 5'b00110,
        opc_store     = 5'b01000,
        opc_store_fp  = 5'b01001,
        opc_amo       = 5'b01011,
        opc_op        = 5'b01100,
        opc_lui       = 5'b01101,
        opc_op_32     = 5'b01110,
        opc_madd      = 5'b10000,
        opc_msub      = 5'b10001,
        opc_nmsub     = 5'b10010,
        opc_nmadd     = 5'b10011,
        opc_op_fp     = 5'b10100,
        opc_branch    = 5'b11000,
        opc_jalr      = 5'b11001,
        opc_jal       = 5'b11011,
        opc_system    = 5'b11100
    } major_opcode_e;

    // backend pipe that executes the instruction
    typedef enum logic [1:0] {
        pipe_none   = 2'd0,
        pipe_xarith = 2'd1,
        pipe_xlogic = 2'd2
    } pipe_e;

    typedef enum logic [0:0] {
        xarith_add = 1'b0,
        xarith_slt = 1'b1
    } xarith_op_e;

    // shf covers sll, srl and sra
    typedef enum logic [1:0] {
        xlogic_and = 2'd0,
        xlogic_or  = 2'd1,
        xlogic_xor = 2'd2,
        xlogic_shf = 2'd3
    } xlogic_op_e;

    typedef struct packed {
        logic [`WARP_REG_ADDR_W-1:0] rd;
        logic [`WARP_REG_ADDR_W-1:0] rs2;
        logic [`WARP_REG_ADDR_W-1:0] rs1;
    } raddr_t;

    typedef struct packed {
        xarith_op_e opsel;
        logic       sub;
        logic       unsigned_cmp;
        logic       word;
    } xarith_ctrl_t;

    typedef struct packed {
        xlogic_op_e opsel;
        logic       word;
    } xlogic_ctrl_t;

    // one decoded instruction, msb first
    typedef struct packed {
        logic                   legal;
        raddr_t                 raddr;
        logic [`WARP_IMM_W-1:0] imm;
        pipe_e                  pipe;
        logic                   op2_sel;
        xarith_ctrl_t           xarith;
        xlogic_ctrl_t           xlogic;
    } bundle_t;

endpackage

// ==== rtl/warp_settings.svh ====
`ifndef WARP_SETTINGS_SVH
`define WARP_SETTINGS_SVH

// instruction word width, uncompressed only
`define WARP_INST_W 32

// immediate width carried in the bundle
// the 64-bit sign extension happens later in the pipe
`define WARP_IMM_W 32

// architectural register index width
`define WARP_REG_ADDR_W 5

// instructions decoded per cycle
`define WARP_LANES 2

`endif

// ==== rtl/warp_skid.sv ====
`timescale 1ns/1ps

`include "warp_settings.svh"

module warp_skid #(
    parameter int DEPTH_LANES = `WARP_LANES
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_input_valid,
    output logic                                o_input_ready,
    input  warp_pkg::bundle_t [DEPTH_LANES-1:0] i_input_data,
    output logic                                o_output_valid,
    input  logic                                i_output_ready,
    output warp_pkg::bundle_t [DEPTH_LANES-1:0] o_output_data
);
    import warp_pkg::*;

    // output stage and the spare entry behind it
    bundle_t [DEPTH_LANES-1:0] out_data;
    bundle_t [DEPTH_LANES-1:0] skid_data;
    logic                      out_valid;
    logic                      skid_valid;

    logic in_fire;
    logic out_load;

    // ready is purely registered, low only while the skid entry is full
    assign in_fire  = i_input_valid && !skid_valid;
    // output stage can take new data when empty or draining
    assign out_load = !out_valid || i_output_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_load) begin
                // skid entry is older, it goes first
                out_valid  <= skid_valid || in_fire;
                skid_valid <= 1'b0;
            end else if (in_fire) begin
                // output stalled, park the new pair
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (out_load) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_fire) begin
                out_data <= i_input_data;
            end
        end
        if (!out_load && in_fire) begin
            skid_data <= i_input_data;
        end
    end

    assign o_input_ready  = !skid_valid;
    assign o_output_valid = out_valid;
    assign o_output_data  = out_data;

endmodule

// ==== rtl/warp_udecode.sv ====
`timescale 1ns/1ps

`include "warp_settings.svh"

module warp_udecode (
    input  logic [`WARP_INST_W-1:0] i_inst,
    output warp_pkg::bundle_t       o_bundle
);
    import warp_pkg::*;

    major_opcode_e               opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [`WARP_REG_ADDR_W-1:0] rd;
    logic [`WARP_REG_ADDR_W-1:0] rs1;
    logic [`WARP_REG_ADDR_W-1:0] rs2;
    logic [`WARP_IMM_W-1:0]      imm;

    // group flags
    logic reg_form;
    logic word_form;
    logic imm_64;

    // funct7 / shamt qualifiers
    logic f7_zero;
    logic f7_alt;
    logic shamt_zero;
    logic shamt_alt;
    logic sll_ok;
    logic srl_ok;

    // decoded controls, before the legality mask
    logic         legal;
    pipe_e        pipe;
    logic         op2_sel;
    xarith_ctrl_t xarith;
    xlogic_ctrl_t xlogic;

    // field slicing
    assign opcode = major_opcode_e'(i_inst[6:2]);
    assign rd     = i_inst[11:7];
    assign funct3 = i_inst[14:12];
    assign rs1    = i_inst[19:15];
    assign rs2    = i_inst[24:20];
    assign funct7 = i_inst[31:25];

    warp_imm_gen u_imm_gen (
        .i_inst  (i_inst),
        .i_opcode(opcode),
        .o_imm   (imm)
    );

    // register-register ops versus immediate ops
    assign reg_form  = (opcode == opc_op) || (opcode == opc_op_32);
    // the -w variants
    assign word_form = (opcode == opc_op_imm_32) || (opcode == opc_op_32);
    // 64-bit shift immediates borrow funct7 bit 25 for shamt[5]
    assign imm_64    = (opcode == opc_op_imm);

    assign f7_zero    = funct7 == 7'b0000000;
    assign f7_alt     = funct7 == 7'b0100000;
    assign shamt_zero = i_inst[31:26] == 6'b000000;
    assign shamt_alt  = i_inst[31:26] == 6'b010000;

    // sll only has the zero encoding, srl/sra also take the alt one
    assign sll_ok = imm_64 ? shamt_zero : f7_zero;
    assign srl_ok = imm_64 ? (shamt_zero || shamt_alt) : (f7_zero || f7_alt);

    always_comb begin
        legal   = 1'b0;
        pipe    = pipe_none;
        op2_sel = 1'b0;
        xarith  = '0;
        xlogic  = '0;

        case (opcode)
            // op-imm, op-imm-32, op, op-32 share the funct3 map
            opc_op_imm, opc_op_imm_32, opc_op, opc_op_32: begin
                case (funct3)
                    // add, sub, addi, addw, subw, addiw
                    3'b000: begin
                        legal        = reg_form ? (f7_zero || f7_alt) : 1'b1;
                        pipe         = pipe_xarith;
                        xarith.opsel = xarith_add;
                    end
                    // sll family
                    3'b001: begin
                        legal        = sll_ok;
                        pipe         = pipe_xlogic;
                        xlogic.opsel = xlogic_shf;
                    end
                    // slt, sltu and immediate forms, no -w variant
                    3'b010, 3'b011: begin
                        legal        = !word_form;
                        pipe         = pipe_xarith;
                        xarith.opsel = xarith_slt;
                    end
                    3'b100: begin
                        legal        = !word_form;
                        pipe         = pipe_xlogic;
                        xlogic.opsel = xlogic_xor;
                    end
                    // srl and sra, funct7[5] picks arithmetic
                    3'b101: begin
                        legal        = srl_ok;
                        pipe         = pipe_xlogic;
                        xlogic.opsel = xlogic_shf;
                    end
                    3'b110: begin
                        legal        = !word_form;
                        pipe         = pipe_xlogic;
                        xlogic.opsel = xlogic_or;
                    end
                    3'b111: begin
                        legal        = !word_form;
                        pipe         = pipe_xlogic;
                        xlogic.opsel = xlogic_and;
                    end
                    default: begin
                        legal = 1'b0;
                    end
                endcase

                // second operand is the immediate for i-type
                op2_sel             = !reg_form;
                xarith.sub          = reg_form && funct7[5];
                xarith.unsigned_cmp = !word_form && funct3[0];
                xarith.word         = word_form;
                xlogic.word         = word_form;
            end
            // lui adds to x0, auipc adds to pc
            opc_lui, opc_auipc: begin
                legal        = 1'b1;
                pipe         = pipe_xarith;
                op2_sel      = 1'b1;
                xarith.opsel = xarith_add;
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // illegal encodings issue nothing, only raddr and imm remain
        if (!legal) begin
            pipe    = pipe_none;
            op2_sel = 1'b0;
            xarith  = '0;
            xlogic  = '0;
        end
    end

    assign o_bundle = '{
        legal:   legal,
        raddr:   '{rd: rd, rs2: rs2, rs1: rs1},
        imm:     imm,
        pipe:    pipe,
        op2_sel: op2_sel,
        xarith:  xarith,
        xlogic:  xlogic
    };

endmodule

// ==== verification/warp_decode_model.svh ====
`ifndef WARP_DECODE_MODEL_SVH
`define WARP_DECODE_MODEL_SVH

// expected immediate, format picked from the major opcode
function automatic logic [31:0] model_imm(input logic [31:0] inst);
    logic [31:0] sx;
    sx = {32{inst[31]}};
    case (major_opcode_e'(inst[6:2]))
        opc_op_imm, opc_op_imm_32, opc_jalr, opc_load: return {sx[31:12], inst[31:20]};
        opc_store:  return {sx[31:12], inst[31:25], inst[11:7]};
        opc_branch: return {sx[31:13], inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        opc_lui, opc_auipc: return {inst[31:12], 12'h000};
        opc_jal:    return {sx[31:21], inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        // r format, funct7 low bits land in 10:5
        default:    return {sx[31:11], inst[30:25], 5'b00000};
    endcase
endfunction

// expected bundle for one instruction
function automatic bundle_t model_decode(input logic [31:0] inst);
    bundle_t       b;
    major_opcode_e opc;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic          alu;
    logic          reg_grp;
    logic          w_grp;
    logic          shl_ok;
    logic          shr_ok;
    opc     = major_opcode_e'(inst[6:2]);
    f3      = inst[14:12];
    f7      = inst[31:25];
    reg_grp = (opc == opc_op) || (opc == opc_op_32);
    w_grp   = (opc == opc_op_imm_32) || (opc == opc_op_32);
    alu     = reg_grp || (opc == opc_op_imm) || (opc == opc_op_imm_32);
    // op-imm has a six bit shamt, only 31:26 qualify it
    if (opc == opc_op_imm) begin
        shl_ok = inst[31:26] == 6'b000000;
        shr_ok = shl_ok || (inst[31:26] == 6'b010000);
    end else begin
        shl_ok = f7 == 7'b0000000;
        shr_ok = shl_ok || (f7 == 7'b0100000);
    end
    b             = '0;
    b.raddr.rd    = inst[11:7];
    b.raddr.rs2   = inst[24:20];
    b.raddr.rs1   = inst[19:15];
    b.imm         = model_imm(inst);
    if (alu) begin
        case (f3)
            3'b000: begin
                b.pipe  = pipe_xarith;
                b.legal = !reg_grp || shr_ok;
            end
            3'b010, 3'b011: begin
                b.pipe         = pipe_xarith;
                b.xarith.opsel = xarith_slt;
                b.legal        = !w_grp;
            end
            3'b001: begin
                b.pipe         = pipe_xlogic;
                b.xlogic.opsel = xlogic_shf;
                b.legal        = shl_ok;
            end
            3'b101: begin
                b.pipe         = pipe_xlogic;
                b.xlogic.opsel = xlogic_shf;
                b.legal        = shr_ok;
            end
            3'b100: begin
                b.pipe         = pipe_xlogic;
                b.xlogic.opsel = xlogic_xor;
                b.legal        = !w_grp;
            end
            3'b110: begin
                b.pipe         = pipe_xlogic;
                b.xlogic.opsel = xlogic_or;
                b.legal        = !w_grp;
            end
            default: begin
                b.pipe         = pipe_xlogic;
                b.xlogic.opsel = xlogic_and;
                b.legal        = !w_grp;
            end
        endcase
        b.op2_sel             = !reg_grp;
        b.xarith.sub          = reg_grp && f7[5];
        b.xarith.unsigned_cmp = !w_grp && f3[0];
        b.xarith.word         = w_grp;
        b.xlogic.word         = w_grp;
    end else if ((opc == opc_lui) || (opc == opc_auipc)) begin
        b.legal   = 1'b1;
        b.pipe    = pipe_xarith;
        b.op2_sel = 1'b1;
    end
    // illegal keeps only raddr and imm
    if (!b.legal) begin
        b.pipe    = pipe_none;
        b.op2_sel = 1'b0;
        b.xarith  = '0;
        b.xlogic  = '0;
    end
    return b;
endfunction

// one lane against its expected bundle
task automatic check_bundle(input string tname, input int lane, input bundle_t exp,
                            input bundle_t act);
    assert (act === exp) else begin
        $display("Fail %s lane %0d expected %h actual %h", tname, lane, exp, act);
        err_count++;
    end
endtask

`endif

// ==== verification/warp_decode_tb.sv ====
`timescale 1ns/1ps

`include "warp_settings.svh"

module warp_decode_tb;
    import warp_pkg::*;

    localparam int TIMEOUT = 50;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_input_valid;
    logic        i_output_ready;
    logic [31:0] i_inst0;
    logic [31:0] i_inst1;
    logic        o_input_ready;
    logic        o_output_valid;
    bundle_t     o_bundle0;
    bundle_t     o_bundle1;

    int      seed;
    int      err_count;
    int      test_err_base;
    int      n_clean;
    int      n_bad;
    int      held_count;
    int      stalls;
    bit      stall_random;
    string   cur_test;
    // two entries per pair, lane 0 first
    bundle_t exp_q[$];

    `include "warp_decode_model.svh"

    warp_decode dut0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_input_valid (i_input_valid),
        .o_input_ready (o_input_ready),
        .i_inst0       (i_inst0),
        .i_inst1       (i_inst1),
        .o_output_valid(o_output_valid),
        .i_output_ready(i_output_ready),
        .o_bundle0     (o_bundle0),
        .o_bundle1     (o_bundle1)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // scoreboard, pop on output transfer then push on input transfer
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            if (o_output_valid && i_output_ready) begin
                if (exp_q.size() < 2) begin
                    $display("%s: output pair arrived with nothing expected", cur_test);
                    err_count++;
                end else begin
                    check_bundle(cur_test, 0, exp_q.pop_front(), o_bundle0);
                    check_bundle(cur_test, 1, exp_q.pop_front(), o_bundle1);
                    held_count--;
                end
            end
            if (i_input_valid && o_input_ready) begin
                exp_q.push_back(model_decode(i_inst0));
                exp_q.push_back(model_decode(i_inst1));
                held_count++;
            end
        end
    end

    reset_outputs: assert property (@(posedge i_clk)
        i_rst_n |=> (o_input_ready && !o_output_valid))
        else begin
            $display("Fail %s expected ready 1 valid 0 actual ready %0b valid %0b",
                     cur_test, $sampled(o_input_ready), $sampled(o_output_valid));
            err_count++;
        end

    stall_hold: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (o_output_valid && !i_output_ready) |=>
        (o_output_valid && $stable(o_bundle0) && $stable(o_bundle1)))
        else begin
            $display("%s: output changed while stalled", cur_test);
            err_count++;
        end

    // ready low exactly when both entries are full
    ready_full: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_input_ready == (held_count < 2))
        else begin
            $display("Fail %s expected input ready %0b actual %0b",
                     cur_test, $sampled(held_count) < 2, $sampled(o_input_ready));
            err_count++;
        end

    drain_ready: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_output_ready |=> o_input_ready)
        else begin
            $display("%s: input ready low after a draining cycle", cur_test);
            err_count++;
        end

    one_cycle: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (i_input_valid && o_input_ready && (!o_output_valid || i_output_ready)) |=>
        o_output_valid)
        else begin
            $display("%s: accepted pair not at output one cycle later", cur_test);
            err_count++;
        end

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input major_opcode_e opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic bit coin();
        return ($random(seed) % 2) != 0;
    endfunction

    // mostly kept opcodes, funct7 often clean so most are legal
    function automatic logic [31:0] random_inst();
        logic [31:0]   r;
        major_opcode_e opc;
        int            pick;
        r    = $random(seed);
        pick = $unsigned($random(seed)) % 8;
        case (pick)
            0:       opc = opc_op_imm;
            1:       opc = opc_op;
            2:       opc = opc_op_imm_32;
            3:       opc = opc_op_32;
            4:       opc = opc_lui;
            5:       opc = opc_auipc;
            default: opc = major_opcode_e'(r[6:2]);
        endcase
        if (r[0]) begin
            r[31:25] = {1'b0, r[30], 5'b00000};
        end
        return {r[31:7], opc, 2'b11};
    endfunction

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = err_count;
    endtask

    task automatic finish_test();
        int errs;
        errs = err_count - test_err_base;
        if (errs == 0) begin
            n_clean++;
            $display("%-14s ok", cur_test);
        end else begin
            n_bad++;
            $display("%-14s %0d errors", cur_test, errs);
        end
    endtask

    // hold the pair until accepted, return cycles spent waiting
    task automatic send_pair(input logic [31:0] inst_a, input logic [31:0] inst_b,
                             output int waited);
        waited = 0;
        @(negedge i_clk);
        i_inst0       = inst_a;
        i_inst1       = inst_b;
        i_input_valid = 1'b1;
        if (stall_random) begin
            i_output_ready = coin();
        end
        while (!o_input_ready && waited < TIMEOUT) begin
            @(negedge i_clk);
            if (stall_random) begin
                i_output_ready = coin();
            end
            waited++;
        end
        if (!o_input_ready) begin
            $display("%s: timeout waiting for input ready", cur_test);
            err_count++;
        end
        @(posedge i_clk);
    endtask

    // stop sending and let the dut empty its output stage
    task automatic drain();
        int waited;
        waited = 0;
        @(negedge i_clk);
        i_input_valid  = 1'b0;
        i_output_ready = 1'b1;
        while (o_output_valid && waited < TIMEOUT) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_output_valid) begin
            $display("%s: timeout waiting for the buffer to drain", cur_test);
            err_count++;
        end
    endtask

    initial begin
        int          w;
        logic [4:0]  r;
        logic [31:0] a;
        logic [31:0] b;
        seed           = 85252;
        err_count      = 0;
        n_clean        = 0;
        n_bad          = 0;
        held_count     = 0;
        stall_random   = 1'b0;
        i_rst_n        = 1'b1;
        i_input_valid  = 1'b0;
        i_output_ready = 1'b1;
        i_inst0        = '0;
        i_inst1        = '0;

        start_test("reset_state");
        // four rising edges with reset high
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b0;
        @(negedge i_clk);
        assert (o_input_ready === 1'b1 && o_output_valid === 1'b0) else begin
            $display("Fail reset_state expected ready 1 valid 0 actual ready %b valid %b",
                     o_input_ready, o_output_valid);
            err_count++;
        end
        finish_test();

        // every funct3 of the four groups, plain and alternate funct7 in one pair
        start_test("alu_decode");
        for (int g = 0; g < 4; g++) begin
            for (int f = 0; f < 8; f++) begin
                r = 5'(g * 8 + f);
                a = enc(7'h00, r, ~r, 3'(f), r + 5'd1, g == 0 ? opc_op : g == 1 ? opc_op_32 :
                        g == 2 ? opc_op_imm : opc_op_imm_32);
                b = {7'h20, a[24:0]};
                send_pair(a, b, w);
            end
        end
        drain();
        finish_test();

        // addi -5, lui, auipc, sd -16, beq -8, and an r form
        start_test("immediate");
        send_pair(enc(7'h7f, 5'b11011, 5'd6, 3'b000, 5'd5, opc_op_imm), 32'habcde3b7, w);
        send_pair(32'h80001417, enc(7'h7f, 5'd9, 5'd10, 3'b011, 5'b10000, opc_store), w);
        send_pair(enc(7'h7f, 5'd12, 5'd11, 3'b000, 5'b11001, opc_branch),
                  enc(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, opc_op), w);
        drain();
        finish_test();

        start_test("illegal");
        send_pair(enc(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, opc_op),
                  enc(7'h20, 5'd2, 5'd1, 3'b001, 5'd3, opc_op), w);
        send_pair(enc(7'h00, 5'd2, 5'd1, 3'b010, 5'd3, opc_op_32),
                  enc(7'h00, 5'd8, 5'd1, 3'b011, 5'd3, opc_load), w);
        send_pair(enc(7'h12, 5'd3, 5'd4, 3'b101, 5'd1, opc_jal),
                  enc(7'h01, 5'd2, 5'd1, 3'b001, 5'd3, opc_op_imm_32), w);
        drain();
        finish_test();

        start_test("throughput");
        stalls = 0;
        for (int i = 0; i < 16; i++) begin
            send_pair(random_inst(), random_inst(), w);
            stalls += w;
        end
        assert (stalls == 0) else begin
            $display("Fail throughput expected 0 stall cycles actual %0d", stalls);
            err_count++;
        end
        drain();
        finish_test();

        start_test("back_pressure");
        stall_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_pair(random_inst(), random_inst(), w);
        end
        stall_random = 1'b0;
        drain();
        assert (exp_q.size() == 0) else begin
            $display("Fail back_pressure expected 0 queued actual %0d", exp_q.size());
            err_count++;
        end
        finish_test();

        $display("%0d tests clean, %0d tests with errors, %0d errors total",
                 n_clean, n_bad, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
+incdir+verification
rtl/warp_pkg.sv
rtl/warp_imm_gen.sv
rtl/warp_udecode.sv
rtl/warp_skid.sv
rtl/warp_decode.sv
verification/warp_decode_tb.sv
